// ==== verilog.f ====
+incdir+include
hdl/icache_addr_pkg.sv
hdl/icache_pipe_pkg.sv
hdl/icache_init_ctrl.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_stage_reg.sv
hdl/icache_lookup.sv
tb/icache_lookup_checker.sv
tb/icache_lookup_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the icache lookup testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module icache_lookup_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vicache_lookup_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi

exit 0

// ==== tb/icache_lookup_tb.sv ====
// ----------------------------------------------------------------------
// Instruction cache lookup testbench
// Drives lookups, refills and flushes against a reference tag model
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_lookup_tb;

  localparam int Ways    = `ICACHE_WAY_COUNT;
  localparam int Lines   = `ICACHE_LINE_COUNT;
  localparam int Timeout = 300;

  logic clk_i;
  logic rst_ni;
  logic flush_valid_i;
  logic flush_ready_o;
  icache_addr_pkg::addr_t  in_addr_i;
  icache_addr_pkg::id_t    in_id_i;
  logic                    in_valid_i;
  logic                    in_ready_o;
  icache_addr_pkg::addr_t  out_addr_o;
  icache_addr_pkg::id_t    out_id_o;
  icache_addr_pkg::way_t   out_set_o;
  logic                    out_hit_o;
  logic                    out_error_o;
  icache_addr_pkg::line_t  out_data_o;
  logic                    out_valid_o;
  logic                    out_ready_i;
  icache_addr_pkg::index_t write_addr_i;
  icache_addr_pkg::way_t   write_set_i;
  icache_addr_pkg::tag_t   write_tag_i;
  logic                    write_error_i;
  icache_addr_pkg::line_t  write_data_i;
  logic                    write_valid_i;
  logic                    write_ready_o;

  // Reference model of the cache contents
  logic                   m_valid [Ways][Lines];
  icache_addr_pkg::tag_t  m_tag   [Ways][Lines];
  logic                   m_err   [Ways][Lines];
  icache_addr_pkg::line_t m_line  [Ways][Lines];

  logic [31:0]           lcg_state;
  int                    tb_errors;
  int                    test_start;
  logic                  stream_done;
  icache_addr_pkg::id_t  next_id;
  icache_addr_pkg::addr_t saved_addr [12];
  icache_addr_pkg::tag_t  tag_pool [4];

  icache_lookup icache_lookup_i (.*);

  icache_lookup_checker u_checker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .out_addr_i  (out_addr_o),
    .out_id_i    (out_id_o),
    .out_set_i   (out_set_o),
    .out_hit_i   (out_hit_o),
    .out_error_i (out_error_o),
    .out_data_i  (out_data_o),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Random numbers and reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic icache_addr_pkg::line_t rand_line();
    return {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
  endfunction

  function automatic icache_addr_pkg::addr_t make_addr(input icache_addr_pkg::tag_t tag,
                                                       input icache_addr_pkg::index_t idx);
    icache_addr_pkg::addr_t a;
    a = icache_addr_pkg::addr_t'(lcg_next());
    a[icache_addr_pkg::LineAlign +: icache_addr_pkg::CountAlign] = idx;
    a[`ICACHE_FETCH_AW-1 -: icache_addr_pkg::TagWidth] = tag;
    return a;
  endfunction

  function automatic void clear_model();
    for (int w = 0; w < Ways; w++) begin
      for (int i = 0; i < Lines; i++) begin
        m_valid[w][i] = 1'b0;
      end
    end
  endfunction

  // Lowest valid way with a matching tag wins
  function automatic void predict_lookup(input icache_addr_pkg::addr_t a, output logic hit,
                                         output icache_addr_pkg::way_t way, output logic err,
                                         output icache_addr_pkg::line_t data);
    icache_addr_pkg::tag_t   t;
    icache_addr_pkg::index_t idx;
    t    = a[`ICACHE_FETCH_AW-1 -: icache_addr_pkg::TagWidth];
    idx  = a[icache_addr_pkg::LineAlign +: icache_addr_pkg::CountAlign];
    hit  = 1'b0;
    way  = '0;
    err  = 1'b0;
    data = '0;
    for (int w = Ways - 1; w >= 0; w--) begin
      if (m_valid[w][idx] && m_tag[w][idx] == t) begin
        hit  = 1'b1;
        way  = icache_addr_pkg::way_t'(w);
        err  = m_err[w][idx];
        data = m_line[w][idx];
      end
    end
  endfunction

  // ----------------------------------------------------------------------
  // Bus tasks, entered and left 1 ns after a rising edge
  // ----------------------------------------------------------------------

  task automatic send_lookup(input icache_addr_pkg::addr_t a);
    logic                   hit;
    icache_addr_pkg::way_t  way;
    logic                   err;
    icache_addr_pkg::line_t data;
    int                     n;
    in_addr_i  = a;
    in_id_i    = next_id;
    in_valid_i = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!in_ready_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (in_ready_o) begin
      predict_lookup(a, hit, way, err, data);
      u_checker.push_expect(a, next_id, hit, way, err, data);
    end else begin
      tb_errors++;
      $display("Timeout: lookup with id %0h was never accepted", next_id);
    end
    next_id++;
    @(posedge clk_i);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic send_write(input icache_addr_pkg::index_t idx, input icache_addr_pkg::way_t way,
                            input icache_addr_pkg::tag_t tag, input logic err,
                            input icache_addr_pkg::line_t data);
    int n;
    write_addr_i  = idx;
    write_set_i   = way;
    write_tag_i   = tag;
    write_error_i = err;
    write_data_i  = data;
    write_valid_i = 1'b1;
    n = 0;
    @(negedge clk_i);
    while (!write_ready_o && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (write_ready_o) begin
      m_valid[way][idx] = 1'b1;
      m_tag[way][idx]   = tag;
      m_err[way][idx]   = err;
      m_line[way][idx]  = data;
    end else begin
      tb_errors++;
      $display("Timeout: refill of index %0d was never accepted", idx);
    end
    @(posedge clk_i);
    #1;
    write_valid_i = 1'b0;
  endtask

  // Returns how many cycles in_ready_o stayed low
  task automatic wait_sweep(output int busy);
    busy = 0;
    @(negedge clk_i);
    while (!in_ready_o && busy < Timeout) begin
      if (write_ready_o) begin
        tb_errors++;
        $display("Refill port was ready at time %0t during the init sweep", $time);
      end
      busy++;
      @(negedge clk_i);
    end
    if (!in_ready_o) begin
      tb_errors++;
      $display("Timeout: init sweep never finished");
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (u_checker.pending() != 0 && n < Timeout) begin
      @(posedge clk_i);
      n++;
    end
    #1;
    if (u_checker.pending() != 0) begin
      tb_errors++;
      $display("Timeout: %0d results never came out", u_checker.pending());
    end
  endtask

  function automatic int total_errors();
    return tb_errors + u_checker.error_count;
  endfunction

  function automatic void report_test(input int num, input string name);
    $display("Test %0d %s: %s", num, name, total_errors() == test_start ? "ok" : "failed");
  endfunction

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    int busy;
    int lat;
    logic [31:0] r;
    lcg_state     = 32'd9769;
    tb_errors     = 0;
    next_id       = '0;
    stream_done   = 1'b0;
    rst_ni        = 1'b0;
    flush_valid_i = 1'b0;
    in_addr_i     = '0;
    in_id_i       = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    write_addr_i  = '0;
    write_set_i   = '0;
    write_tag_i   = '0;
    write_error_i = 1'b0;
    write_data_i  = '0;
    write_valid_i = 1'b0;
    clear_model();
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Cold cache misses everywhere
    test_start = total_errors();
    wait_sweep(busy);
    for (int k = 0; k < 10; k++) begin
      send_lookup(icache_addr_pkg::addr_t'(lcg_next()));
    end
    wait_drain();
    report_test(1, "cold misses");

    // Refills then hits and misses
    test_start = total_errors();
    for (int k = 0; k < 12; k++) begin
      r = lcg_next();
      saved_addr[k] = make_addr(icache_addr_pkg::tag_t'(lcg_next()), r[3:0]);
      send_write(r[3:0], r[8], saved_addr[k][`ICACHE_FETCH_AW-1 -: icache_addr_pkg::TagWidth],
                 r[12], rand_line());
    end
    for (int k = 0; k < 12; k++) begin
      send_lookup(saved_addr[k]);
    end
    for (int k = 0; k < 6; k++) begin
      send_lookup(saved_addr[k] ^ (32'h1 << 31));
    end
    wait_drain();
    report_test(2, "refill hits");

    // Flush forgets everything
    test_start = total_errors();
    flush_valid_i = 1'b1;
    busy = 0;
    @(negedge clk_i);
    while (!flush_ready_o && busy < Timeout) begin
      @(negedge clk_i);
      busy++;
    end
    if (!flush_ready_o) begin
      tb_errors++;
      $display("Timeout: flush request was never accepted");
    end
    clear_model();
    @(posedge clk_i);
    #1;
    flush_valid_i = 1'b0;
    wait_sweep(busy);
    if (busy != Lines) begin
      tb_errors++;
      $display("Sweep after flush held in_ready_o low for %0d cycles, not %0d", busy, Lines);
    end
    for (int k = 0; k < 12; k++) begin
      send_lookup(saved_addr[k]);
    end
    wait_drain();
    report_test(3, "flush sweep");

    // Two cycles from handshake to output
    test_start = total_errors();
    for (int k = 0; k < 8; k++) begin
      send_lookup(saved_addr[k]);
      lat = 1;
      @(negedge clk_i);
      while (!out_valid_o && lat < Timeout) begin
        lat++;
        @(negedge clk_i);
      end
      if (lat != 2) begin
        tb_errors++;
        $display("Output came %0d cycles after the request handshake, not 2", lat);
      end
      @(posedge clk_i);
      #1;
    end
    wait_drain();
    report_test(4, "latency");

    // Back-pressure with refills to the upper half of the indices
    test_start = total_errors();
    for (int k = 0; k < 8; k++) begin
      r = lcg_next();
      if (k < 4) begin
        tag_pool[k] = icache_addr_pkg::tag_t'(lcg_next());
      end
      send_write(icache_addr_pkg::index_t'(k), r[4], tag_pool[k % 4], r[9], rand_line());
    end
    fork
      begin
        fork
          for (int k = 0; k < 40; k++) begin
            r = lcg_next();
            send_lookup(make_addr(tag_pool[r[5:4]], {1'b0, r[2:0]}));
          end
          for (int k = 0; k < 20; k++) begin
            r = lcg_next();
            send_write({1'b1, r[2:0]}, r[6], icache_addr_pkg::tag_t'(lcg_next()), r[7],
                       rand_line());
          end
        join
        stream_done = 1'b1;
      end
      begin
        lat = 0;
        while (!stream_done && lat < 20 * Timeout) begin
          @(posedge clk_i);
          #1;
          r = lcg_next();
          out_ready_i = r[13];
          lat++;
        end
        out_ready_i = 1'b1;
      end
    join
    wait_drain();
    report_test(5, "back-pressure");

    if (u_checker.pending() != 0) begin
      tb_errors++;
      $display("%0d expected results were never produced", u_checker.pending());
    end
    $display("Outputs checked: %0d, matched: %0d, errors: %0d",
             u_checker.check_count, u_checker.match_count, total_errors());
    if (total_errors() == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/icache_lookup_checker.sv ====
// ----------------------------------------------------------------------
// Instruction cache lookup checker
// Matches each output handshake against queued expectations in order
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module icache_lookup_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input icache_addr_pkg::addr_t out_addr_i,
  input icache_addr_pkg::id_t   out_id_i,
  input icache_addr_pkg::way_t  out_set_i,
  input logic                   out_hit_i,
  input logic                   out_error_i,
  input icache_addr_pkg::line_t out_data_i,
  input logic                   out_valid_i,
  input logic                   out_ready_i
);

  typedef struct packed {
    icache_addr_pkg::addr_t addr;
    icache_addr_pkg::id_t   id;
    logic                   hit;
    icache_addr_pkg::way_t  way;
    logic                   error;
    icache_addr_pkg::line_t data;
  } expect_t;

  expect_t exp_q[$];

  int error_count = 0;
  int check_count = 0;
  int match_count = 0;

  // Output seen while stalled at the previous sample
  logic    stall_q = 1'b0;
  expect_t last_q;

  task automatic push_expect(input icache_addr_pkg::addr_t addr, input icache_addr_pkg::id_t id,
                             input logic hit, input icache_addr_pkg::way_t way,
                             input logic error, input icache_addr_pkg::line_t data);
    expect_t e;
    e.addr  = addr;
    e.id    = id;
    e.hit   = hit;
    e.way   = way;
    e.error = error;
    e.data  = data;
    exp_q.push_back(e);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  // Outputs are sampled mid-cycle where they are stable
  always @(negedge clk_i) begin : sample
    expect_t e;
    if (!rst_ni) begin
      stall_q = 1'b0;
    end else begin
      if (stall_q && (!out_valid_i || out_addr_i != last_q.addr || out_id_i != last_q.id ||
                      out_hit_i != last_q.hit || out_set_i != last_q.way ||
                      out_error_i != last_q.error ||
                      (out_hit_i && out_data_i != last_q.data))) begin
        error_count++;
        $display("Mismatch at %0t: output id %0h changed while not taken", $time, last_q.id);
      end
      if (out_valid_i && out_ready_i) begin
        check_count++;
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Output with id %0h at time %0t arrived with no request waiting",
                   out_id_i, $time);
        end else begin
          e = exp_q.pop_front();
          if (out_addr_i != e.addr || out_id_i != e.id || out_hit_i != e.hit) begin
            error_count++;
            $display("Mismatch at %0t: got id %0h addr %h hit %b, want id %0h addr %h hit %b",
                     $time, out_id_i, out_addr_i, out_hit_i, e.id, e.addr, e.hit);
          end else if (e.hit && (out_set_i != e.way || out_error_i != e.error)) begin
            error_count++;
            $display("Mismatch at %0t: id %0h way %0d err %b, want way %0d err %b",
                     $time, e.id, out_set_i, out_error_i, e.way, e.error);
          end else if (e.hit && out_data_i != e.data) begin
            error_count++;
            $display("Mismatch at %0t: id %0h line %h, want %h", $time, e.id, out_data_i, e.data);
          end else begin
            match_count++;
          end
        end
      end
      stall_q      = out_valid_i && !out_ready_i;
      last_q.addr  = out_addr_i;
      last_q.id    = out_id_i;
      last_q.hit   = out_hit_i;
      last_q.way   = out_set_i;
      last_q.error = out_error_i;
      last_q.data  = out_data_i;
    end
  end

endmodule

// ==== hdl/icache_lookup.sv ====
// ----------------------------------------------------------------------
// Instruction cache lookup pipeline
// Tag stage and data stage with refill port and flush sweep
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module icache_lookup (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_valid_i,
  output logic                    flush_ready_o,
  input  icache_addr_pkg::addr_t  in_addr_i,
  input  icache_addr_pkg::id_t    in_id_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output icache_addr_pkg::addr_t  out_addr_o,
  output icache_addr_pkg::id_t    out_id_o,
  output icache_addr_pkg::way_t   out_set_o,
  output logic                    out_hit_o,
  output logic                    out_error_o,
  output icache_addr_pkg::line_t  out_data_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  input  icache_addr_pkg::index_t write_addr_i,
  input  icache_addr_pkg::way_t   write_set_i,
  input  icache_addr_pkg::tag_t   write_tag_i,
  input  logic                    write_error_i,
  input  icache_addr_pkg::line_t  write_data_i,
  input  logic                    write_valid_i,
  output logic                    write_ready_o
);

  logic                    init_busy;
  icache_addr_pkg::index_t clear_index;
  logic                    write_accept;
  logic                    lookup_accept;

  icache_pipe_pkg::lookup_req_t tag_req_d, tag_req_q;
  logic                         tag_in_ready, tag_valid;
  logic                         tag_hit, tag_error, kill_q;
  icache_addr_pkg::way_t        tag_way;
  icache_addr_pkg::index_t      lookup_index;

  icache_pipe_pkg::data_req_t data_req_d, data_req_q;
  logic                       data_in_ready, data_read;

  icache_init_ctrl u_init_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o),
    .busy_o        (init_busy),
    .clear_index_o (clear_index)
  );

  // ----------------------------------------------------------------------
  // Tag stage
  // ----------------------------------------------------------------------

  // Refills are only refused while the sweep runs
  assign write_ready_o = !init_busy;
  assign write_accept  = write_valid_i && write_ready_o;

  assign in_ready_o    = tag_in_ready && !init_busy;
  assign lookup_accept = in_valid_i && in_ready_o;

  assign tag_req_d.addr = in_addr_i;
  assign tag_req_d.id   = in_id_i;

  icache_stage_reg #(
    .payload_t (icache_pipe_pkg::lookup_req_t)
  ) u_tag_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i && !init_busy),
    .in_ready_o  (tag_in_ready),
    .in_data_i   (tag_req_d),
    .stall_i     (write_accept),
    .out_valid_o (tag_valid),
    .out_ready_i (data_in_ready),
    .out_data_o  (tag_req_q)
  );

  icache_tag_array u_tag_array (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (init_busy),
    .clear_index_i (clear_index),
    .wr_valid_i    (write_accept),
    .wr_index_i    (write_addr_i),
    .wr_way_i      (write_set_i),
    .wr_tag_i      (write_tag_i),
    .wr_error_i    (write_error_i),
    .rd_valid_i    (lookup_accept),
    .rd_addr_i     (in_addr_i),
    .hit_o         (tag_hit),
    .way_o         (tag_way),
    .error_o       (tag_error)
  );

  assign lookup_index = tag_req_q.addr[icache_addr_pkg::LineAlign +: icache_addr_pkg::CountAlign];

  // A refill over the line we hit makes the waiting result stale
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kill_q <= 1'b0;
    end else if (lookup_accept) begin
      kill_q <= 1'b0;
    end else if (write_accept && tag_valid && write_set_i == tag_way &&
                 write_addr_i == lookup_index) begin
      kill_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------------------
  // Data stage
  // ----------------------------------------------------------------------

  assign data_req_d.addr  = tag_req_q.addr;
  assign data_req_d.id    = tag_req_q.id;
  assign data_req_d.way   = tag_way;
  assign data_req_d.hit   = tag_hit && !kill_q;
  assign data_req_d.error = tag_error;

  icache_stage_reg #(
    .payload_t (icache_pipe_pkg::data_req_t)
  ) u_data_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (tag_valid),
    .in_ready_o  (data_in_ready),
    .in_data_i   (data_req_d),
    .stall_i     (write_accept),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (data_req_q)
  );

  // Misses skip the line read
  assign data_read = tag_valid && data_in_ready && data_req_d.hit;

  icache_data_array u_data_array (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (write_accept),
    .wr_index_i (write_addr_i),
    .wr_way_i   (write_set_i),
    .wr_data_i  (write_data_i),
    .rd_valid_i (data_read),
    .rd_index_i (lookup_index),
    .rd_way_i   (tag_way),
    .hold_i     (out_valid_o && !out_ready_i),
    .rd_data_o  (out_data_o)
  );

  assign out_addr_o  = data_req_q.addr;
  assign out_id_o    = data_req_q.id;
  assign out_set_o   = data_req_q.way;
  assign out_hit_o   = data_req_q.hit;
  assign out_error_o = data_req_q.error;

endmodule

// ==== hdl/icache_stage_reg.sv ====
// ----------------------------------------------------------------------
// Instruction cache stage register
// Single-entry valid/ready pipeline register for any payload type
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module icache_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  input  logic     stall_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;
  payload_t data_q;
  logic     in_fire;

  // Room when empty or when the current item leaves this cycle
  assign in_ready_o = (!valid_q || out_ready_i) && !stall_i;
  assign in_fire    = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (in_fire) begin
      valid_q <= 1'b1;
    end else if (out_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  // Downstream may rely on an offered item not changing
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o)
  ) else $error("stage payload changed while stalled");

endmodule

// ==== hdl/icache_data_array.sv ====
// ----------------------------------------------------------------------
// Instruction cache data array
// Line storage with write priority and a hold register on the read side
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_data_array (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    wr_valid_i,
  input  icache_addr_pkg::index_t wr_index_i,
  input  icache_addr_pkg::way_t   wr_way_i,
  input  icache_addr_pkg::line_t  wr_data_i,
  input  logic                    rd_valid_i,
  input  icache_addr_pkg::index_t rd_index_i,
  input  icache_addr_pkg::way_t   rd_way_i,
  input  logic                    hold_i,
  output icache_addr_pkg::line_t  rd_data_o
);

  icache_addr_pkg::line_t mem [`ICACHE_WAY_COUNT][`ICACHE_LINE_COUNT];

  icache_addr_pkg::index_t rd_index_q;
  icache_addr_pkg::way_t   rd_way_q;
  logic                    rd_pending_q;
  icache_addr_pkg::line_t  mem_rdata;
  icache_addr_pkg::line_t  hold_q;

  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem[wr_way_i][wr_index_i] <= wr_data_i;
    end
  end

  // A write in the same cycle takes the port
  always_ff @(posedge clk_i) begin
    if (rd_valid_i && !wr_valid_i) begin
      rd_index_q <= rd_index_i;
      rd_way_q   <= rd_way_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
    end else begin
      rd_pending_q <= rd_valid_i && !wr_valid_i;
    end
  end

  assign mem_rdata = mem[rd_way_q][rd_index_q];

  // Keep the line if nobody takes it in the cycle after the read
  always_ff @(posedge clk_i) begin
    if (rd_pending_q && hold_i) begin
      hold_q <= mem_rdata;
    end
  end

  assign rd_data_o = rd_pending_q ? mem_rdata : hold_q;

endmodule

// ==== hdl/icache_tag_array.sv ====
// ----------------------------------------------------------------------
// Instruction cache tag array
// Stores valid, error and tag per way and index, compares on lookup
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_tag_array (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  icache_addr_pkg::index_t clear_index_i,
  input  logic                    wr_valid_i,
  input  icache_addr_pkg::index_t wr_index_i,
  input  icache_addr_pkg::way_t   wr_way_i,
  input  icache_addr_pkg::tag_t   wr_tag_i,
  input  logic                    wr_error_i,
  input  logic                    rd_valid_i,
  input  icache_addr_pkg::addr_t  rd_addr_i,
  output logic                    hit_o,
  output icache_addr_pkg::way_t   way_o,
  output logic                    error_o
);

  localparam int unsigned TagLsb = icache_addr_pkg::LineAlign + icache_addr_pkg::CountAlign;

  // Storage per way and index
  icache_addr_pkg::tag_t tag_mem [`ICACHE_WAY_COUNT][`ICACHE_LINE_COUNT];
  logic valid_mem [`ICACHE_WAY_COUNT][`ICACHE_LINE_COUNT];
  logic error_mem [`ICACHE_WAY_COUNT][`ICACHE_LINE_COUNT];

  icache_addr_pkg::index_t rd_index;
  logic                    rd_en;

  // Read port registers
  icache_addr_pkg::addr_t   rd_addr_q;
  icache_addr_pkg::tag_t    rd_tag_q [`ICACHE_WAY_COUNT];
  logic [`ICACHE_WAY_COUNT-1:0] rd_line_valid_q;
  logic [`ICACHE_WAY_COUNT-1:0] rd_error_q;
  logic [`ICACHE_WAY_COUNT-1:0] way_hit;

  assign rd_index = rd_addr_i[icache_addr_pkg::LineAlign +: icache_addr_pkg::CountAlign];

  // Clearing beats refills, refills beat lookups
  assign rd_en = rd_valid_i && !clear_i && !wr_valid_i;

  always_ff @(posedge clk_i) begin
    if (clear_i) begin
      for (int w = 0; w < `ICACHE_WAY_COUNT; w++) begin
        valid_mem[w][clear_index_i] <= 1'b0;
        error_mem[w][clear_index_i] <= 1'b0;
        tag_mem[w][clear_index_i]   <= '0;
      end
    end else if (wr_valid_i) begin
      valid_mem[wr_way_i][wr_index_i] <= 1'b1;
      error_mem[wr_way_i][wr_index_i] <= wr_error_i;
      tag_mem[wr_way_i][wr_index_i]   <= wr_tag_i;
    end
  end

  // ----------------------------------------------------------------------
  // Registered read
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_line_valid_q <= '0;
      rd_error_q      <= '0;
    end else if (rd_en) begin
      for (int w = 0; w < `ICACHE_WAY_COUNT; w++) begin
        rd_line_valid_q[w] <= valid_mem[w][rd_index];
        rd_error_q[w]      <= error_mem[w][rd_index];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rd_addr_q <= rd_addr_i;
      for (int w = 0; w < `ICACHE_WAY_COUNT; w++) begin
        rd_tag_q[w] <= tag_mem[w][rd_index];
      end
    end
  end

  // Compare against the tag field of the registered address
  always_comb begin
    for (int w = 0; w < `ICACHE_WAY_COUNT; w++) begin
      way_hit[w] = rd_line_valid_q[w] &&
                   (rd_tag_q[w] == rd_addr_q[TagLsb +: icache_addr_pkg::TagWidth]);
    end
  end

  assign hit_o = |way_hit;

  // Walk down so the lowest hitting way wins
  always_comb begin
    way_o   = '0;
    error_o = 1'b0;
    for (int w = `ICACHE_WAY_COUNT - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        way_o   = icache_addr_pkg::way_t'(w);
        error_o = rd_error_q[w];
      end
    end
  end

endmodule

// ==== hdl/icache_init_ctrl.sv ====
// ----------------------------------------------------------------------
// Instruction cache init controller
// Sweeps all tag lines after reset and after each accepted flush
// ----------------------------------------------------------------------

`timescale 1ns/1ps

`include "icache_defs.svh"

module icache_init_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_valid_i,
  output logic                   flush_ready_o,
  output logic                   busy_o,
  output icache_addr_pkg::index_t clear_index_o
);

  // One extra bit so the counter can rest at the line count
  localparam int unsigned CntWidth = icache_addr_pkg::CountAlign + 1;
  localparam logic [CntWidth-1:0] CntDone = CntWidth'(`ICACHE_LINE_COUNT);

  logic [CntWidth-1:0] count_q;

  assign busy_o        = count_q != CntDone;
  assign flush_ready_o = !busy_o;
  assign clear_index_o = count_q[icache_addr_pkg::CountAlign-1:0];

  // Sweep starts right out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (busy_o) begin
      count_q <= count_q + 1'b1;
    end else if (flush_valid_i) begin
      count_q <= '0;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  a_count_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntDone
  ) else $error("init sweep counter ran past the line count");

endmodule

// ==== hdl/icache_pipe_pkg.sv ====
// ----------------------------------------------------------------------
// Instruction cache pipeline payloads
// Requests carried by the tag stage and the data stage
// ----------------------------------------------------------------------

package icache_pipe_pkg;

  // --------------------------------------------------------------------
  // Tag stage
  // --------------------------------------------------------------------

  // Fetch request waiting for its tag compare
  typedef struct packed {
    icache_addr_pkg::addr_t addr;
    icache_addr_pkg::id_t   id;
  } lookup_req_t;

  // --------------------------------------------------------------------
  // Data stage
  // --------------------------------------------------------------------

  // Request with its lookup result attached
  typedef struct packed {
    icache_addr_pkg::addr_t addr;
    icache_addr_pkg::id_t   id;
    // Lowest way that matched
    icache_addr_pkg::way_t  way;
    logic                   hit;
    // Error flag stored with the hitting line
    logic                   error;
  } data_req_t;

endpackage

// ==== hdl/icache_addr_pkg.sv ====
// ----------------------------------------------------------------------
// Instruction cache address fields
// Field widths and the address, tag, index, way, line and ID types
// ----------------------------------------------------------------------

`include "icache_defs.svh"

package icache_addr_pkg;

  // --------------------------------------------------------------------
  // Field widths
  // --------------------------------------------------------------------

  // Byte offset within a line
  localparam int unsigned LineAlign = $clog2(`ICACHE_LINE_WIDTH / 8);

  // Line index within a way
  localparam int unsigned CountAlign = $clog2(`ICACHE_LINE_COUNT);

  // Way select
  localparam int unsigned SetAlign = $clog2(`ICACHE_WAY_COUNT);

  // Whatever is left above index and offset
  localparam int unsigned TagWidth = `ICACHE_FETCH_AW - CountAlign - LineAlign;

  // --------------------------------------------------------------------
  // Types
  // --------------------------------------------------------------------

  typedef logic [`ICACHE_FETCH_AW-1:0] addr_t;

  typedef logic [TagWidth-1:0] tag_t;

  typedef logic [CountAlign-1:0] index_t;

  typedef logic [SetAlign-1:0] way_t;

  typedef logic [`ICACHE_LINE_WIDTH-1:0] line_t;

  typedef logic [`ICACHE_ID_WIDTH-1:0] id_t;

endpackage

// ==== include/icache_defs.svh ====
// ----------------------------------------------------------------------
// Instruction cache lookup configuration
// Sizes of the fetch address, cache lines, ways and request IDs
// ----------------------------------------------------------------------

`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// ----------------------------------------------------------------------
// Fetch interface
// ----------------------------------------------------------------------

// Width of a fetch address in bits
`define ICACHE_FETCH_AW 32

// Width of the request ID that travels with each lookup
`define ICACHE_ID_WIDTH 4

// ----------------------------------------------------------------------
// Cache geometry
// ----------------------------------------------------------------------

// Bits per cache line
`define ICACHE_LINE_WIDTH 128

// Lines per way, also the length of the init sweep
`define ICACHE_LINE_COUNT 16

// Set associativity
`define ICACHE_WAY_COUNT 2

`endif
